//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rvx_tb
FILELIST  ?= tb.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/rvx_alu.sv
//**********************************************************
// combinational ALU for the seven arithmetic/logic opcodes
// shifts use only the low bits of b (b modulo XLEN)
// any other opcode passes a through unchanged
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "rvx_settings.svh"

module rvx_alu
   import rvx_pkg::*;
(
   input  wire rvx_op_e                op,
   input  wire logic [`RVX_XLEN-1:0]   a,
   input  wire logic [`RVX_XLEN-1:0]   b,
   output logic      [`RVX_XLEN-1:0]   y
);

   localparam int SHAMT_W = $clog2(`RVX_XLEN);

   logic [SHAMT_W-1:0] shamt;

   // shift amount from the second operand
   assign shamt = b[SHAMT_W-1:0];

   always_comb begin
      case (op)
         OP_ADD: begin
            y = a + b;
         end
         OP_SUB: begin
            y = a - b;
         end
         OP_AND: begin
            y = a & b;
         end
         OP_OR: begin
            y = a | b;
         end
         OP_XOR: begin
            y = a ^ b;
         end
         OP_SLL: begin
            y = a << shamt;
         end
         OP_SRL: begin
            y = a >> shamt;
         end
         // read, swap and rotate steer porta through here
         default: begin
            y = a;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/rvx_ctrl.sv
//**********************************************************
// req/ack sequencer for the register-operation engine
// request fields must stay stable until ack is seen high
// single-step ops write one edge after acceptance,
// rotate writes on two edges and needs distinct nonzero
// indices; ack holds while req stays high
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "rvx_settings.svh"

module rvx_ctrl
   import rvx_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   // requester side
   input  wire logic                   req,
   input  wire rvx_op_e                op,
   input  wire logic [`RVX_IDX_W-1:0]  rd_idx,
   input  wire logic [`RVX_IDX_W-1:0]  rs1_idx,
   input  wire logic [`RVX_IDX_W-1:0]  rs2_idx,
   input  wire logic [`RVX_XLEN-1:0]   imm,
   output logic                        ack,
   output logic      [`RVX_XLEN-1:0]   result,
   // register file and ALU data
   input  wire logic [`RVX_XLEN-1:0]   porta,
   input  wire logic [`RVX_XLEN-1:0]   portb,
   input  wire logic [`RVX_XLEN-1:0]   alu_y,
   // register file control
   output logic      [`RVX_IDX_W-1:0]  sel_porta,
   output logic      [`RVX_IDX_W-1:0]  sel_portb,
   output logic      [`RVX_IDX_W-1:0]  sel_rd,
   output logic      [`RVX_IDX_W-1:0]  sel_rd2,
   output logic      [`RVX_XLEN-1:0]   wr_data,
   output logic      [`RVX_XLEN-1:0]   wr_data2,
   output logic                        write_rd,
   output logic                        write_rd2,
   output logic                        allow_hidden_use_of_x0
);

   rvx_state_e state;
   rvx_state_e state_nxt;

   logic [`RVX_XLEN-1:0] result_nxt;

   //**********************************************************
   // state machine
   //**********************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (req) begin
               state_nxt = ST_EXEC;
            end
         end
         ST_EXEC: begin
            state_nxt = (op == OP_ROT3) ? ST_ROT2 : ST_ACK;
         end
         ST_ROT2: begin
            state_nxt = ST_ACK;
         end
         ST_ACK: begin
            // back-pressure: hold until req drops
            if (!req) begin
               state_nxt = ST_IDLE;
            end
         end
      endcase
   end

   assign ack = (state == ST_ACK);

   //**********************************************************
   // register file steering
   //**********************************************************

   always_comb begin
      sel_porta              = rs1_idx;
      sel_portb              = rs2_idx;
      sel_rd                 = rd_idx;
      sel_rd2                = rs2_idx;
      wr_data                = alu_y;
      wr_data2               = porta;
      write_rd               = 1'b0;
      write_rd2              = 1'b0;
      allow_hidden_use_of_x0 = 1'b0;
      case (state)
         ST_EXEC: begin
            case (op)
               OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: begin
                  write_rd = 1'b1;
               end
               OP_LI: begin
                  wr_data  = imm;
                  write_rd = 1'b1;
               end
               OP_SWAP: begin
                  // rs1 <= old rs2, rs2 <= old rs1
                  sel_rd    = rs1_idx;
                  wr_data   = portb;
                  sel_rd2   = rs2_idx;
                  wr_data2  = porta;
                  write_rd  = 1'b1;
                  write_rd2 = 1'b1;
               end
               OP_ROT3: begin
                  // step one: rd <= old rs2, x0 <= old rd
                  allow_hidden_use_of_x0 = 1'b1;
                  sel_porta = rd_idx;
                  sel_rd    = rd_idx;
                  wr_data   = portb;
                  sel_rd2   = '0;
                  wr_data2  = porta;
                  write_rd  = 1'b1;
                  write_rd2 = 1'b1;
               end
               default: begin
                  // read only, nothing written
               end
            endcase
         end
         ST_ROT2: begin
            // step two: rs2 <= old rs1, rs1 <= parked copy in x0
            allow_hidden_use_of_x0 = 1'b1;
            sel_portb = '0;
            sel_rd    = rs2_idx;
            wr_data   = porta;
            sel_rd2   = rs1_idx;
            wr_data2  = portb;
            write_rd  = 1'b1;
            write_rd2 = 1'b1;
         end
         default: begin
         end
      endcase
   end

   //**********************************************************
   // result register
   //**********************************************************

   // porta holds old rs1 for read/swap, old rd for rotate
   always_comb begin
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: begin
            result_nxt = alu_y;
         end
         OP_LI: begin
            result_nxt = imm;
         end
         default: begin
            result_nxt = porta;
         end
      endcase
   end

   // captured on the first execute edge, held through ack
   always_ff @(posedge clk) begin
      if (state == ST_EXEC) begin
         result <= result_nxt;
      end
   end

endmodule

`default_nettype wire

//--- logic/rvx_pkg.sv
//**********************************************************
// shared types of the register-operation engine
// opcode values are part of the requester interface
// and must not be renumbered
//**********************************************************
`default_nettype none

package rvx_pkg;

   // operation codes seen on the op port
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLL  = 4'd5,
      OP_SRL  = 4'd6,
      OP_LI   = 4'd7,
      OP_READ = 4'd8,
      OP_SWAP = 4'd9,
      OP_ROT3 = 4'd10
   } rvx_op_e;

   // control sequencer states
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_EXEC = 2'd1,
      ST_ROT2 = 2'd2,
      ST_ACK  = 2'd3
   } rvx_state_e;

endpackage

`default_nettype wire

//--- logic/rvx_regfile.sv
//**********************************************************
// two-read, two-write register file
// reads are combinational, writes land on the rising edge
// same index on both write ports: port 1 wins
// x0 reads zero and drops writes unless the hidden flag
// is set, which only the micro-sequence does
// asynchronous reset clears every word
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "rvx_settings.svh"

module rvx_regfile (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   // read selects
   input  wire logic [`RVX_IDX_W-1:0]  sel_porta,
   input  wire logic [`RVX_IDX_W-1:0]  sel_portb,
   // write selects
   input  wire logic [`RVX_IDX_W-1:0]  sel_rd,
   input  wire logic [`RVX_IDX_W-1:0]  sel_rd2,
   // write data and enables
   input  wire logic [`RVX_XLEN-1:0]   rd,
   input  wire logic [`RVX_XLEN-1:0]   rd2,
   input  wire logic                   write_rd,
   input  wire logic                   write_rd2,
   // lets the micro-sequence park a value in x0
   input  wire logic                   allow_hidden_use_of_x0,
   // read data
   output logic      [`RVX_XLEN-1:0]   porta,
   output logic      [`RVX_XLEN-1:0]   portb
);

   logic [`RVX_XLEN-1:0] regs [`RVX_NUM_REGS];

   logic wr1_ok;
   logic wr2_ok;

   //**********************************************************
   // read ports
   //**********************************************************

   assign porta = ((sel_porta != '0) || allow_hidden_use_of_x0) ? regs[sel_porta] : '0;
   assign portb = ((sel_portb != '0) || allow_hidden_use_of_x0) ? regs[sel_portb] : '0;

   //**********************************************************
   // write ports
   //**********************************************************

   // x0 is writable only while hidden
   assign wr1_ok = write_rd  && ((sel_rd  != '0) || allow_hidden_use_of_x0);
   assign wr2_ok = write_rd2 && ((sel_rd2 != '0) || allow_hidden_use_of_x0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `RVX_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wr2_ok) begin
            regs[sel_rd2] <= rd2;
         end
         // port 1 last, so it overrides port 2 on the same index
         if (wr1_ok) begin
            regs[sel_rd] <= rd;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/rvx_settings.svh
//**********************************************************
// global widths for the register-operation engine
// index width must cover the register count exactly,
// so every select addresses a real word
// data width is also the shift range of the ALU
//**********************************************************
`ifndef RVX_SETTINGS_SVH
`define RVX_SETTINGS_SVH

// data path width
`define RVX_XLEN 32

// register file depth, x0 included
`define RVX_NUM_REGS 32

// register index width
`define RVX_IDX_W 5

`endif

//--- logic/rvx_top.sv
//**********************************************************
// register-operation engine top level
// one operation at a time over a four-phase req/ack
// no forwarding, no error response
// result is valid only while ack is high
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "rvx_settings.svh"

module rvx_top
   import rvx_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   req,
   input  wire rvx_op_e                op,
   input  wire logic [`RVX_IDX_W-1:0]  rd_idx,
   input  wire logic [`RVX_IDX_W-1:0]  rs1_idx,
   input  wire logic [`RVX_IDX_W-1:0]  rs2_idx,
   input  wire logic [`RVX_XLEN-1:0]   imm,
   output logic                        ack,
   output logic      [`RVX_XLEN-1:0]   result
);

   // register file selects
   logic [`RVX_IDX_W-1:0] sel_porta;
   logic [`RVX_IDX_W-1:0] sel_portb;
   logic [`RVX_IDX_W-1:0] sel_rd;
   logic [`RVX_IDX_W-1:0] sel_rd2;

   // data paths
   logic [`RVX_XLEN-1:0]  porta;
   logic [`RVX_XLEN-1:0]  portb;
   logic [`RVX_XLEN-1:0]  wr_data;
   logic [`RVX_XLEN-1:0]  wr_data2;
   logic [`RVX_XLEN-1:0]  alu_y;

   logic                  write_rd;
   logic                  write_rd2;
   logic                  allow_hidden_use_of_x0;

   rvx_ctrl u_ctrl (
      .clk                    (clk),
      .rst_n                  (rst_n),
      .req                    (req),
      .op                     (op),
      .rd_idx                 (rd_idx),
      .rs1_idx                (rs1_idx),
      .rs2_idx                (rs2_idx),
      .imm                    (imm),
      .ack                    (ack),
      .result                 (result),
      .porta                  (porta),
      .portb                  (portb),
      .alu_y                  (alu_y),
      .sel_porta              (sel_porta),
      .sel_portb              (sel_portb),
      .sel_rd                 (sel_rd),
      .sel_rd2                (sel_rd2),
      .wr_data                (wr_data),
      .wr_data2               (wr_data2),
      .write_rd               (write_rd),
      .write_rd2              (write_rd2),
      .allow_hidden_use_of_x0 (allow_hidden_use_of_x0)
   );

   rvx_regfile u_regfile (
      .clk                    (clk),
      .rst_n                  (rst_n),
      .sel_porta              (sel_porta),
      .sel_portb              (sel_portb),
      .sel_rd                 (sel_rd),
      .sel_rd2                (sel_rd2),
      .rd                     (wr_data),
      .rd2                    (wr_data2),
      .write_rd               (write_rd),
      .write_rd2              (write_rd2),
      .allow_hidden_use_of_x0 (allow_hidden_use_of_x0),
      .porta                  (porta),
      .portb                  (portb)
   );

   // operands come straight from the read ports
   rvx_alu u_alu (
      .op                     (op),
      .a                      (porta),
      .b                      (portb),
      .y                      (alu_y)
   );

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/rvx_pkg.sv
logic/rvx_regfile.sv
logic/rvx_alu.sv
logic/rvx_ctrl.sv
logic/rvx_top.sv
verification/rvx_sva.sv
verification/rvx_tb.sv

//--- verification/rvx_sva.sv
//**********************************************************
// req/ack handshake assertions, bound into the top level
// two rules are idle while reset is low; the third looks
// at the first edge after reset release
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module rvx_sva (
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic req,
   input  wire logic ack
);

   // ack answers a request sampled one edge earlier
   a_ack_needs_req : assert property (
      @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
   ) else $error("ack rose without a request");

   // back-pressure: ack holds while req stays high
   a_ack_holds : assert property (
      @(posedge clk) disable iff (!rst_n) (ack && req) |=> ack
   ) else $error("ack dropped while req was still high");

   a_ack_low_after_reset : assert property (
      @(posedge clk) $rose(rst_n) |-> !ack
   ) else $error("ack high right after reset release");

endmodule

bind rvx_top rvx_sva u_sva (
   .clk   (clk),
   .rst_n (rst_n),
   .req   (req),
   .ack   (ack)
);

`default_nettype wire

//--- verification/rvx_tb.sv
//**********************************************************
// testbench for the register-operation engine
// a model of the register file predicts every result
// and written registers are read back through OP_READ
// the first mismatch ends the run
// a watchdog bounds the run time
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "rvx_settings.svh"

module rvx_tb
   import rvx_pkg::*;
();

   localparam int XW         = `RVX_XLEN;
   localparam int IW         = `RVX_IDX_W;
   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 5;
   localparam int N_ALU      = 40;
   localparam int N_SWAP     = 6;
   localparam int N_ROT      = 6;
   localparam int N_BP       = 4;
   localparam int BP_HOLD    = 6;
   // reset reads, LI fill with read-back, ALU, swap, rotate, back-pressure, final reads
   localparam int NUM_OPS = `RVX_NUM_REGS * 4 + N_ALU * 2 + N_SWAP * 3 + N_ROT * 5 + N_BP * 2;
   localparam int WATCHDOG_NS = (RST_CYCLES + NUM_OPS * 12) * CLK_PERIOD * 2;

   logic          clk;
   logic          rst_n;
   logic          req;
   rvx_op_e       op;
   logic [IW-1:0] rd_idx;
   logic [IW-1:0] rs1_idx;
   logic [IW-1:0] rs2_idx;
   logic [XW-1:0] imm;
   logic          ack;
   logic [XW-1:0] result;

   // reference register file where x0 stays zero
   logic [XW-1:0] model_regs [`RVX_NUM_REGS];
   logic [XW-1:0] expected_q [$];
   logic          ack_prev;
   integer        seed = 74;

   rvx_top DUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .op      (op),
      .rd_idx  (rd_idx),
      .rs1_idx (rs1_idx),
      .rs2_idx (rs2_idx),
      .imm     (imm),
      .ack     (ack),
      .result  (result)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run("timeout: the engine stopped answering requests");
   end

   //**********************************************************
   // helpers
   //**********************************************************

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [XW-1:0] got,
                              input logic [XW-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("error: %s = 0x%08h, expected 0x%08h", name, got, exp));
      end
   endtask

   function automatic logic [XW-1:0] rand_word();
      rand_word = $random(seed);
   endfunction

   function automatic logic [IW-1:0] rand_idx(input logic nonzero);
      logic [XW-1:0] w;
      w = rand_word();
      if (nonzero && (w[IW-1:0] == '0)) begin
         w[0] = 1'b1;
      end
      rand_idx = w[IW-1:0];
   endfunction

   function automatic int random_hold();
      logic [XW-1:0] w;
      w = rand_word();
      random_hold = int'(w[1:0]);
   endfunction

   function automatic rvx_op_e rand_alu_op();
      logic [XW-1:0] w;
      w = rand_word() % 7;
      rand_alu_op = rvx_op_e'(w[3:0]);
   endfunction

   function automatic void model_write(input logic [IW-1:0] idx, input logic [XW-1:0] val);
      if (idx != '0) begin
         model_regs[idx] = val;
      end
   endfunction

   // updates the model and returns the expected result
   function automatic logic [XW-1:0] model_apply(input rvx_op_e o, input logic [IW-1:0] d,
                                                 input logic [IW-1:0] s1,
                                                 input logic [IW-1:0] s2,
                                                 input logic [XW-1:0] v);
      logic [XW-1:0] a;
      logic [XW-1:0] b;
      logic [XW-1:0] y;
      a = model_regs[s1];
      b = model_regs[s2];
      y = a;
      case (o)
         OP_ADD: y = a + b;
         OP_SUB: y = a - b;
         OP_AND: y = a & b;
         OP_OR:  y = a | b;
         OP_XOR: y = a ^ b;
         OP_SLL: y = a << b[4:0];
         OP_SRL: y = a >> b[4:0];
         OP_LI:  y = v;
         OP_SWAP: begin
            // rs1 wins when both name the same register
            model_write(s2, a);
            model_write(s1, b);
         end
         OP_ROT3: begin
            // rd <- rs2, rs2 <- rs1, rs1 <- rd
            y = model_regs[d];
            model_write(d, b);
            model_write(s2, a);
            model_write(s1, y);
         end
         default: begin
         end
      endcase
      if ((o <= OP_SRL) || (o == OP_LI)) begin
         model_write(d, y);
      end
      model_apply = y;
   endfunction

   // one four-phase transaction with req held hold cycles past ack
   task automatic run_op(input rvx_op_e o, input logic [IW-1:0] d, input logic [IW-1:0] s1,
                         input logic [IW-1:0] s2, input logic [XW-1:0] v, input int hold);
      expected_q.push_back(model_apply(o, d, s1, s2, v));
      op      = o;
      rd_idx  = d;
      rs1_idx = s1;
      rs2_idx = s2;
      imm     = v;
      req     = 1'b1;
      do begin
         @(negedge clk);
      end while (!ack);
      repeat (hold) begin
         @(negedge clk);
         check_value("ack", {{(XW-1){1'b0}}, ack}, 32'd1);
      end
      req = 1'b0;
      do begin
         @(negedge clk);
      end while (ack);
   endtask

   task automatic read_back(input logic [IW-1:0] idx);
      run_op(OP_READ, '0, idx, '0, '0, random_hold());
   endtask

   //**********************************************************
   // result compare on each rising ack
   //**********************************************************

   always @(negedge clk) begin
      logic rose;
      rose     = rst_n && ack && !ack_prev;
      ack_prev = ack;
      if (rose) begin
         if (expected_q.size() == 0) begin
            abort_run("ack rose with no request pending");
         end else begin
            check_value("result", result, expected_q.pop_front());
         end
      end
   end

   //**********************************************************
   // stimulus
   //**********************************************************

   initial begin
      logic [IW-1:0] d;
      logic [IW-1:0] s1;
      logic [IW-1:0] s2;
      rst_n    = 1'b0;
      req      = 1'b0;
      op       = OP_READ;
      rd_idx   = '0;
      rs1_idx  = '0;
      rs2_idx  = '0;
      imm      = '0;
      ack_prev = 1'b0;
      for (int r = 0; r < `RVX_NUM_REGS; r++) begin
         model_regs[r] = '0;
      end
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // everything reads zero after reset
      for (int r = 0; r < `RVX_NUM_REGS; r++) begin
         read_back(r[IW-1:0]);
      end

      // load-immediate fill and a dropped write to x0
      for (int r = 1; r < `RVX_NUM_REGS; r++) begin
         run_op(OP_LI, r[IW-1:0], '0, '0, rand_word(), random_hold());
         read_back(r[IW-1:0]);
      end
      run_op(OP_LI, '0, '0, '0, 32'hdead_beef, 0);
      read_back('0);

      // random ALU traffic with x0 forced now and then
      for (int i = 0; i < N_ALU; i++) begin
         d  = (i % 5 == 0) ? '0 : rand_idx(1'b0);
         s1 = (i % 7 == 0) ? '0 : rand_idx(1'b0);
         s2 = rand_idx(1'b0);
         run_op(rand_alu_op(), d, s1, s2, rand_word(), random_hold());
         read_back(d);
      end

      for (int i = 0; i < N_SWAP; i++) begin
         s1 = (i == 0) ? '0 : rand_idx(1'b0);
         s2 = rand_idx(1'b1);
         run_op(OP_SWAP, '0, s1, s2, '0, random_hold());
         read_back(s1);
         read_back(s2);
      end

      // rotate needs three distinct nonzero indices
      for (int i = 0; i < N_ROT; i++) begin
         d  = rand_idx(1'b1);
         s1 = rand_idx(1'b1);
         s2 = rand_idx(1'b1);
         while (s1 == d) begin
            s1 = rand_idx(1'b1);
         end
         while ((s2 == d) || (s2 == s1)) begin
            s2 = rand_idx(1'b1);
         end
         run_op(OP_ROT3, d, s1, s2, '0, random_hold());
         read_back(d);
         read_back(s1);
         read_back(s2);
         read_back('0);
      end

      // back-pressure bursts
      // rd accumulates, so a repeated add would show in the read-back
      for (int i = 0; i < N_BP; i++) begin
         d = rand_idx(1'b1);
         run_op(OP_ADD, d, d, rand_idx(1'b1), '0, BP_HOLD);
         read_back(d);
      end

      for (int r = 0; r < `RVX_NUM_REGS; r++) begin
         read_back(r[IW-1:0]);
      end

      // no ack without a request after the last operation
      repeat (4) begin
         @(negedge clk);
         check_value("ack", {{(XW-1){1'b0}}, ack}, '0);
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire
